// File: Bender.yml
package:
  name: ising_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/ising_pkg.sv
      - hw/ising_weight_store.sv
      - hw/ising_host_port.sv
      - hw/ising_sweep_engine.sv
      - hw/ising_result_fifo.sv
      - hw/ising_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_ising_core.sv

// File: bench/tb_ising_core.sv
// Self-checking random testbench for the Ising core, compares every sweep result with a model
`include "ising_consts.svh"

module tb_ising_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYC = 2000;

    logic                     clk;
    logic                     rst_n;
    ising_pkg::ising_cmd_t    cmd;
    logic                     cmd_valid;
    logic                     cmd_ready;
    ising_pkg::ising_result_t res;
    logic                     res_valid;
    logic                     res_ready;

    // Reference weights, J[row][col] and H[spin]
    int                       j_m [`ISING_NUM_SPIN][`ISING_NUM_SPIN];
    int                       h_m [`ISING_NUM_SPIN];
    ising_pkg::ising_result_t exp_q [$];

    ising_core uut (
        .clk_i       (clk      ),
        .rst_n_i     (rst_n    ),
        .cmd_i       (cmd      ),
        .cmd_valid_i (cmd_valid),
        .cmd_ready_o (cmd_ready),
        .res_o       (res      ),
        .res_valid_o (res_valid),
        .res_ready_i (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Checks
    ////////////////////
    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // Fields shown as spins/sweep/flips/last
    task automatic check_result(input ising_pkg::ising_result_t got,
                                input ising_pkg::ising_result_t exp);
        if (got !== exp) begin
            $display("Fail %0t res_o got %b/%0d/%0d/%b exp %b/%0d/%0d/%b",
                     $time, got.spins, got.sweep, got.flips, got.last,
                     exp.spins, exp.sweep, exp.flips, exp.last);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %b exp %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////
    // Sequential sweeps, updated spins are used at once
    function automatic void model_anneal(input logic [`ISING_NUM_SPIN-1:0] spins0, input int n);
        logic [`ISING_NUM_SPIN-1:0] s;
        ising_pkg::ising_result_t   r;
        int                         f;
        int                         fl;
        logic                       nb;
        s = spins0;
        for (int sw = 0; sw < n; sw++) begin
            fl = 0;
            for (int i = 0; i < `ISING_NUM_SPIN; i++) begin
                f = h_m[i];
                for (int k = 0; k < `ISING_NUM_SPIN; k++) begin
                    if (k != i) begin
                        f = s[k] ? f + j_m[i][k] : f - j_m[i][k];
                    end
                end
                if (f > 0) begin
                    nb = 1'b1;
                end else if (f < 0) begin
                    nb = 1'b0;
                end else begin
                    nb = s[i];
                end
                if (nb != s[i]) begin
                    fl++;
                end
                s[i] = nb;
            end
            r.spins = s;
            r.sweep = `ISING_SWEEP_W'(sw);
            r.flips = `ISING_FLIP_W'(fl);
            r.last  = (sw == n - 1);
            exp_q.push_back(r);
        end
    endfunction

    ////////////////////
    // Host side
    ////////////////////
    // All tasks start and end 1 ns after a rising edge
    task automatic wait_cmd_ready();
        int n;
        n = 0;
        while (!cmd_ready) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYC) begin
                $display("Timeout at %0t, cmd_ready_o never came back high", $time);
                stop_on_error();
            end
        end
    endtask

    task automatic send_cmd(input ising_pkg::ising_cmd_t c);
        wait_cmd_ready();
        cmd       = c;
        cmd_valid = 1'b1;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    function automatic ising_pkg::ising_cmd_t ctrl_cmd(input ising_pkg::ising_mode_e mode,
                                                        input int sweeps,
                                                        input logic [`ISING_NUM_SPIN-1:0] spins);
        ising_pkg::ising_cmd_t c;
        c                     = '0;
        c.op                  = ising_pkg::OP_CTRL;
        c.payload.ctrl.mode   = mode;
        c.payload.ctrl.sweeps = `ISING_SWEEP_W'(sweeps);
        c.payload.ctrl.spins  = spins;
        return c;
    endfunction

    // Eight J rows then H, the model follows only when keep is set
    task automatic load_weights(input bit keep);
        ising_pkg::ising_cmd_t c;
        int                    v;
        for (int r = 0; r <= `ISING_NUM_SPIN; r++) begin
            c     = '0;
            c.op  = (r < `ISING_NUM_SPIN) ? ising_pkg::OP_WR_J : ising_pkg::OP_WR_H;
            c.row = `ISING_IDX_W'(r);
            for (int k = 0; k < `ISING_NUM_SPIN; k++) begin
                v = int'($urandom_range(0, 15)) - 8;
                c.payload.weights[k] = ising_pkg::ising_j_t'(v);
                if (keep && r < `ISING_NUM_SPIN) begin
                    j_m[r][k] = v;
                end else if (keep) begin
                    h_m[k] = v;
                end
            end
            send_cmd(c);
        end
    endtask

    // Start an anneal and take every result, with random stalls when bp is set
    task automatic run_anneal(input logic [`ISING_NUM_SPIN-1:0] spins0, input int n, input bit bp);
        ising_pkg::ising_result_t exp;
        int                       n_cyc;
        int                       stretch;
        logic                     rdy;
        model_anneal(spins0, n);
        send_cmd(ctrl_cmd(ising_pkg::MODE_ANNEAL, n, spins0));
        n_cyc   = 0;
        stretch = 0;
        rdy     = 1'b1;
        while (exp_q.size() > 0) begin
            if (bp) begin
                // Stretches longer than two sweeps fill the buffer and stall the engine
                if (stretch == 0) begin
                    rdy     = $urandom_range(0, 1);
                    stretch = $urandom_range(1, 24);
                end
                stretch--;
            end
            res_ready = rdy;
            // Outputs are registered, so a handshake now pops at the next edge
            if (res_valid && res_ready) begin
                exp = exp_q.pop_front();
                check_result(res, exp);
            end
            @(posedge clk);
            #1;
            n_cyc++;
            if (n_cyc > TIMEOUT_CYC) begin
                $display("Timeout at %0t, %0d results still missing", $time, exp_q.size());
                stop_on_error();
            end
        end
        res_ready = 1'b1;
        wait_cmd_ready();
        // Nothing beyond the expected results
        check_bit("res_valid_o", res_valid, 1'b0);
    endtask

    task automatic zero_sweep_run();
        send_cmd(ctrl_cmd(ising_pkg::MODE_ANNEAL, 0, `ISING_NUM_SPIN'($urandom)));
        for (int i = 0; i < 16; i++) begin
            check_bit("res_valid_o", res_valid, 1'b0);
            check_bit("cmd_ready_o", cmd_ready, 1'b1);
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        void'($urandom(26256));
        rst_n     = 1'b0;
        cmd       = '0;
        cmd_valid = 1'b0;
        res_ready = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        check_bit("cmd_ready_o", cmd_ready, 1'b0);
        check_bit("res_valid_o", res_valid, 1'b0);
        rst_n     = 1'b1;
        res_ready = 1'b1;
        @(posedge clk);
        #1;
        check_bit("cmd_ready_o", cmd_ready, 1'b1);
        check_bit("res_valid_o", res_valid, 1'b0);

        // Load then anneal, a few rounds
        for (int rnd = 0; rnd < 3; rnd++) begin
            send_cmd(ctrl_cmd(ising_pkg::MODE_LOAD, 0, '0));
            load_weights(1'b1);
            run_anneal(`ISING_NUM_SPIN'($urandom), $urandom_range(1, 10), 1'b0);
        end

        // Weight writes in idle mode must be dropped
        load_weights(1'b0);
        run_anneal(`ISING_NUM_SPIN'($urandom), $urandom_range(1, 10), 1'b0);

        // Back-pressure on the result port
        for (int rnd = 0; rnd < 3; rnd++) begin
            send_cmd(ctrl_cmd(ising_pkg::MODE_LOAD, 0, '0));
            load_weights(1'b1);
            run_anneal(`ISING_NUM_SPIN'($urandom), $urandom_range(6, 20), 1'b1);
        end

        // Zero sweeps, then a normal run to show the core still works
        zero_sweep_run();
        run_anneal(`ISING_NUM_SPIN'($urandom), $urandom_range(1, 8), 1'b1);

        $display("TEST OK");
        $finish;
    end

endmodule

// File: hw/ising_consts.svh
// Sizing constants for the Ising core, included by the package and the sized RTL modules
`ifndef ISING_CONSTS_SVH
`define ISING_CONSTS_SVH

// Problem size
`define ISING_NUM_SPIN 8
`define ISING_IDX_W    3

// Signed weight widths
// J row and H vector share one 32-bit word layout
`define ISING_BIT_J    4
`define ISING_BIT_H    4

// Local field accumulator
// Seven products of magnitude 8 plus the bias fit easily
`define ISING_FIELD_W  10

// Sweep and flip counters
`define ISING_SWEEP_W  6
`define ISING_FLIP_W   4

`endif

// File: hw/ising_core.sv
// Top level of the Ising annealing core, wires host port, weight store, sweep engine and result buffer
`include "ising_consts.svh"

module ising_core (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  ising_pkg::ising_cmd_t    cmd_i,
    input  logic                     cmd_valid_i,
    output logic                     cmd_ready_o,
    output ising_pkg::ising_result_t res_o,
    output logic                     res_valid_o,
    input  logic                     res_ready_i
);

    ising_pkg::ising_wr_t       wr;
    logic                       start;
    logic [`ISING_NUM_SPIN-1:0] init_spins;
    logic [`ISING_SWEEP_W-1:0]  sweeps;
    logic                       done;
    logic [`ISING_IDX_W-1:0]    rd_row;
    ising_pkg::ising_wvec_t     j_row;
    ising_pkg::ising_wvec_t     h_vec;
    ising_pkg::ising_result_t   eng_res;
    logic                       eng_valid;
    logic                       eng_ready;

    ////////////////////
    // Input side
    ////////////////////
    ising_host_port i_host_port (
        .clk_i        (clk_i      ),
        .rst_n_i      (rst_n_i    ),
        .cmd_i        (cmd_i      ),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .wr_o         (wr         ),
        .start_o      (start      ),
        .init_spins_o (init_spins ),
        .sweeps_o     (sweeps     ),
        .done_i       (done       )
    );

    ////////////////////
    // Processing
    ////////////////////
    ising_weight_store i_weight_store (
        .clk_i    (clk_i  ),
        .rst_n_i  (rst_n_i),
        .wr_i     (wr     ),
        .rd_row_i (rd_row ),
        .j_row_o  (j_row  ),
        .h_vec_o  (h_vec  )
    );

    ising_sweep_engine i_sweep_engine (
        .clk_i        (clk_i     ),
        .rst_n_i      (rst_n_i   ),
        .start_i      (start     ),
        .init_spins_i (init_spins),
        .sweeps_i     (sweeps    ),
        .rd_row_o     (rd_row    ),
        .j_row_i      (j_row     ),
        .h_vec_i      (h_vec     ),
        .res_o        (eng_res   ),
        .res_valid_o  (eng_valid ),
        .res_ready_i  (eng_ready ),
        .done_o       (done      )
    );

    ////////////////////
    // Output side
    ////////////////////
    ising_result_fifo i_result_fifo (
        .clk_i        (clk_i      ),
        .rst_n_i      (rst_n_i    ),
        .push_i       (eng_res    ),
        .push_valid_i (eng_valid  ),
        .push_ready_o (eng_ready  ),
        .res_o        (res_o      ),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i)
    );

endmodule

// File: hw/ising_host_port.sv
// Command input side of the Ising core, decodes host commands and owns the mode register
`include "ising_consts.svh"

module ising_host_port (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  ising_pkg::ising_cmd_t      cmd_i,
    input  logic                       cmd_valid_i,
    output logic                       cmd_ready_o,
    output ising_pkg::ising_wr_t       wr_o,
    output logic                       start_o,
    output logic [`ISING_NUM_SPIN-1:0] init_spins_o,
    output logic [`ISING_SWEEP_W-1:0]  sweeps_o,
    input  logic                       done_i
);

    ising_pkg::ising_mode_e     mode_q;
    ising_pkg::ising_mode_e     mode_d;
    ising_pkg::ising_ctrl_t     ctrl;
    logic                       accept;
    logic                       is_ctrl;
    logic                       go_anneal;
    logic                       ready_q;
    logic                       start_q;
    logic                       j_we_q;
    logic                       h_we_q;
    logic [`ISING_IDX_W-1:0]    row_q;
    ising_pkg::ising_wvec_t     data_q;
    logic [`ISING_NUM_SPIN-1:0] spins_q;
    logic [`ISING_SWEEP_W-1:0]  sweeps_q;

    assign accept    = cmd_valid_i && cmd_ready_o;
    assign ctrl      = cmd_i.payload.ctrl;
    assign is_ctrl   = accept && (cmd_i.op == ising_pkg::OP_CTRL);
    // A zero sweep count never enters anneal
    assign go_anneal = is_ctrl && (ctrl.mode == ising_pkg::MODE_ANNEAL) && (ctrl.sweeps != '0);

    ////////////////////
    // Mode register
    ////////////////////
    always_comb begin
        mode_d = mode_q;
        if (done_i) begin
            mode_d = ising_pkg::MODE_IDLE;
        end else if (is_ctrl) begin
            case (ctrl.mode)
                ising_pkg::MODE_LOAD:   mode_d = ising_pkg::MODE_LOAD;
                ising_pkg::MODE_ANNEAL: mode_d = go_anneal ? ising_pkg::MODE_ANNEAL
                                                           : ising_pkg::MODE_IDLE;
                default:                mode_d = ising_pkg::MODE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mode_q  <= ising_pkg::MODE_IDLE;
            ready_q <= 1'b0;
            start_q <= 1'b0;
            j_we_q  <= 1'b0;
            h_we_q  <= 1'b0;
        end else begin
            mode_q  <= mode_d;
            ready_q <= (mode_d != ising_pkg::MODE_ANNEAL);
            start_q <= go_anneal;
            // Weight writes only land in load mode
            j_we_q  <= accept && (mode_q == ising_pkg::MODE_LOAD)
                       && (cmd_i.op == ising_pkg::OP_WR_J);
            h_we_q  <= accept && (mode_q == ising_pkg::MODE_LOAD)
                       && (cmd_i.op == ising_pkg::OP_WR_H);
        end
    end

    ////////////////////
    // Payload capture
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (accept) begin
            row_q  <= cmd_i.row;
            data_q <= cmd_i.payload.weights;
        end
        if (go_anneal) begin
            spins_q  <= ctrl.spins;
            sweeps_q <= ctrl.sweeps;
        end
    end

    assign cmd_ready_o  = ready_q;
    assign start_o      = start_q;
    assign init_spins_o = spins_q;
    assign sweeps_o     = sweeps_q;
    assign wr_o         = '{j_we: j_we_q, h_we: h_we_q, row: row_q, data: data_q};

endmodule

// File: hw/ising_pkg.sv
// Shared command, payload, weight-store and result types, referenced by scoped names
`include "ising_consts.svh"

package ising_pkg;

    // Operating mode held by the host port
    typedef enum logic [1:0] {
        MODE_IDLE   = 2'd0,
        MODE_LOAD   = 2'd1,
        MODE_ANNEAL = 2'd2
    } ising_mode_e;

    // Command opcodes
    typedef enum logic [1:0] {
        OP_WR_J = 2'd0,
        OP_WR_H = 2'd1,
        OP_CTRL = 2'd2
    } ising_op_e;

    // One signed coupling or bias entry
    typedef logic signed [`ISING_BIT_J-1:0] ising_j_t;

    // Eight entries packed into one word, used for a J row and for H
    typedef ising_j_t [`ISING_NUM_SPIN-1:0] ising_wvec_t;

    // Control view of the payload word
    typedef struct packed {
        logic [32-2-`ISING_SWEEP_W-`ISING_NUM_SPIN-1:0] pad;
        logic [`ISING_NUM_SPIN-1:0]                     spins;
        logic [`ISING_SWEEP_W-1:0]                      sweeps;
        ising_mode_e                                    mode;
    } ising_ctrl_t;

    // Payload word, decoded by opcode
    typedef union packed {
        ising_wvec_t weights;
        ising_ctrl_t ctrl;
    } ising_payload_u;

    typedef struct packed {
        ising_op_e                 op;
        logic [`ISING_IDX_W-1:0]   row;
        ising_payload_u            payload;
    } ising_cmd_t;

    // Weight-store write port
    typedef struct packed {
        logic                      j_we;
        logic                      h_we;
        logic [`ISING_IDX_W-1:0]   row;
        ising_wvec_t               data;
    } ising_wr_t;

    // One result per sweep
    typedef struct packed {
        logic [`ISING_NUM_SPIN-1:0] spins;
        logic [`ISING_SWEEP_W-1:0]  sweep;
        logic [`ISING_FLIP_W-1:0]   flips;
        logic                       last;
    } ising_result_t;

endpackage

// File: hw/ising_result_fifo.sv
// Two-entry result buffer on the output side, decouples the engine from host back-pressure
module ising_result_fifo (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  ising_pkg::ising_result_t push_i,
    input  logic                     push_valid_i,
    output logic                     push_ready_o,
    output ising_pkg::ising_result_t res_o,
    output logic                     res_valid_o,
    input  logic                     res_ready_i
);

    ising_pkg::ising_result_t mem_q [2];
    // Pointers carry one wrap bit above the slot index
    logic [1:0]               wr_ptr_q;
    logic [1:0]               rd_ptr_q;
    logic                     full;
    logic                     empty;
    logic                     push;
    logic                     pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[1] != rd_ptr_q[1]) && (wr_ptr_q[0] == rd_ptr_q[0]);
    assign push  = push_valid_i && !full;
    assign pop   = res_ready_i && !empty;

    ////////////////////
    // Pointers
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q[0]] <= push_i;
        end
    end

    assign push_ready_o = !full;
    assign res_valid_o  = !empty;
    assign res_o        = mem_q[rd_ptr_q[0]];

endmodule

// File: hw/ising_sweep_engine.sv
// Sequential spin-update engine, one spin per cycle, one result offered per sweep
`include "ising_consts.svh"

module ising_sweep_engine (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       start_i,
    input  logic [`ISING_NUM_SPIN-1:0] init_spins_i,
    input  logic [`ISING_SWEEP_W-1:0]  sweeps_i,
    output logic [`ISING_IDX_W-1:0]    rd_row_o,
    input  ising_pkg::ising_wvec_t     j_row_i,
    input  ising_pkg::ising_wvec_t     h_vec_i,
    output ising_pkg::ising_result_t   res_o,
    output logic                       res_valid_o,
    input  logic                       res_ready_i,
    output logic                       done_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_OFFER
    } state_e;

    state_e                          state_q;
    logic [`ISING_IDX_W-1:0]         idx_q;
    logic                            done_q;
    logic [`ISING_NUM_SPIN-1:0]      spins_q;
    logic [`ISING_NUM_SPIN-1:0]      spins_nxt;
    logic [`ISING_SWEEP_W-1:0]       sweep_q;
    logic [`ISING_SWEEP_W-1:0]       tot_q;
    logic [`ISING_FLIP_W-1:0]        flips_q;
    logic [`ISING_FLIP_W-1:0]        flips_nxt;
    logic signed [`ISING_FIELD_W-1:0] field;
    logic                            spin_new;
    logic                            flip;
    logic                            last_idx;
    ising_pkg::ising_result_t        res_q;

    assign last_idx = (idx_q == `ISING_IDX_W'(`ISING_NUM_SPIN - 1));

    ////////////////////
    // Local field
    ////////////////////
    // h_i plus J[i][j] times +1/-1 for every other spin
    always_comb begin
        field = $signed(h_vec_i[idx_q]);
        for (int k = 0; k < `ISING_NUM_SPIN; k++) begin
            if (k != idx_q) begin
                if (spins_q[k]) begin
                    field = field + $signed(j_row_i[k]);
                end else begin
                    field = field - $signed(j_row_i[k]);
                end
            end
        end
    end

    // Zero field keeps the current spin
    always_comb begin
        if (field > 0) begin
            spin_new = 1'b1;
        end else if (field < 0) begin
            spin_new = 1'b0;
        end else begin
            spin_new = spins_q[idx_q];
        end
        spins_nxt        = spins_q;
        spins_nxt[idx_q] = spin_new;
    end

    assign flip      = spin_new ^ spins_q[idx_q];
    assign flips_nxt = flips_q + {{(`ISING_FLIP_W-1){1'b0}}, flip};

    ////////////////////
    // Sweep control
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            idx_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_RUN;
                        idx_q   <= '0;
                    end
                end
                S_RUN: begin
                    // Index wraps back to zero after the last spin
                    idx_q <= idx_q + 1'b1;
                    if (last_idx) begin
                        state_q <= S_OFFER;
                    end
                end
                S_OFFER: begin
                    // Stall here until the result buffer takes the result
                    if (res_ready_i) begin
                        if (res_q.last) begin
                            state_q <= S_IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            state_q <= S_RUN;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Spin state, counters and the pending result
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && start_i) begin
            spins_q <= init_spins_i;
            tot_q   <= sweeps_i;
            sweep_q <= '0;
            flips_q <= '0;
        end else if (state_q == S_RUN) begin
            spins_q <= spins_nxt;
            flips_q <= flips_nxt;
            if (last_idx) begin
                res_q.spins <= spins_nxt;
                res_q.sweep <= sweep_q;
                res_q.flips <= flips_nxt;
                res_q.last  <= ((sweep_q + 1'b1) == tot_q);
            end
        end else if (state_q == S_OFFER && res_ready_i) begin
            sweep_q <= sweep_q + 1'b1;
            flips_q <= '0;
        end
    end

    assign rd_row_o    = idx_q;
    assign res_o       = res_q;
    assign res_valid_o = (state_q == S_OFFER);
    assign done_o      = done_q;

endmodule

// File: hw/ising_weight_store.sv
// Register-file store for the J rows and H vector, written by the host port, read by the engine
`include "ising_consts.svh"

module ising_weight_store (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  ising_pkg::ising_wr_t    wr_i,
    input  logic [`ISING_IDX_W-1:0] rd_row_i,
    output ising_pkg::ising_wvec_t  j_row_o,
    output ising_pkg::ising_wvec_t  h_vec_o
);

    ising_pkg::ising_wvec_t j_q [`ISING_NUM_SPIN];
    ising_pkg::ising_wvec_t h_q;

    ////////////////////
    // J rows
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < `ISING_NUM_SPIN; r++) begin
                j_q[r] <= '0;
            end
        end else if (wr_i.j_we) begin
            j_q[wr_i.row] <= wr_i.data;
        end
    end

    ////////////////////
    // H vector
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            h_q <= '0;
        end else if (wr_i.h_we) begin
            h_q <= wr_i.data;
        end
    end

    // Asynchronous row read for the sweep engine
    assign j_row_o = j_q[rd_row_i];
    assign h_vec_o = h_q;

endmodule

// File: project.f
+incdir+hw
hw/ising_pkg.sv
hw/ising_weight_store.sv
hw/ising_host_port.sv
hw/ising_sweep_engine.sv
hw/ising_result_fifo.sv
hw/ising_core.sv
bench/tb_ising_core.sv
